/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_mem_subsys
FILELIST := build.f
BUILD    := obj_dir
SIM_BIN  := $(BUILD)/V$(TOP)
LOG      := sim.log
PASS_MSG := Simulation passed
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM_BIN)
	-./$(SIM_BIN) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* build.f */
hw/mem_pkg.sv
hw/axi_mem.sv
hw/line_fill.sv
hw/store_port.sv
hw/mem_subsys.sv
verif/tb_clock.sv
verif/mem_subsys_assert.sv
verif/tb_mem_subsys.sv

/* hw/axi_mem.sv */
/*
 * AXI4 memory slave.
 * Serves incrementing word read bursts and single-beat strobed writes
 * over a word array. Reads have priority over writes when both are
 * pending in idle. Accesses outside the window answer decerr.
 */
`timescale 1ns/1ps
`default_nettype none

module axi_mem import mem_pkg::*; (
    input  wire         clk,
    input  wire         reset,

    // read address
    input  wire  [31:0] araddr,
    input  wire  [7:0]  arlen,
    input  wire  [2:0]  arsize,
    input  wire         arvalid,
    output logic        arready,

    // read data
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    output logic        rlast,
    input  wire         rready,

    // write address and data
    input  wire  [31:0] awaddr,
    input  wire         awvalid,
    output logic        awready,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  wstrb,
    input  wire         wvalid,
    input  wire         wlast,
    output logic        wready,

    // write response
    output logic        bvalid,
    output logic [1:0]  bresp,
    input  wire         bready
);

    logic [31:0] mem [mem_words];

    logic [2:0]  state;
    logic [31:0] rd_addr;
    logic [7:0]  rd_len;
    logic [7:0]  rd_cnt;
    logic        rd_size_ok;

    logic        ar_fire;
    logic        r_fire;
    logic        rd_more;
    logic        w_fire;
    logic [31:0] fetch_addr;
    logic        fetch_hit;
    logic        wr_hit;

    function automatic logic in_window(input logic [31:0] addr);
        return (addr >= base_addr) && ((addr - base_addr) < 32'(mem_words * 4));
    endfunction

    function automatic logic [mem_idx_bits-1:0] word_idx(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - base_addr;
        return offset[mem_idx_bits+1:2];
    endfunction

    assign ar_fire = (state == ms_rd_addr) && arvalid && arready;
    assign r_fire  = rvalid && rready;
    assign rd_more = (state == ms_rd_data) && r_fire && (rd_cnt != rd_len);
    assign w_fire  = (state == ms_wr) && awvalid && awready && wvalid && wready;

    // first beat from the request, later beats step one word
    assign fetch_addr = ar_fire ? {araddr[31:2], 2'b00} : rd_addr + 32'd4;
    // only word beats are served
    assign fetch_hit  = in_window(fetch_addr) && (ar_fire ? (arsize == 3'd2) : rd_size_ok);
    assign wr_hit     = in_window(awaddr) && wlast;

    // ------------------------------------------------------------------------
    // control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ms_idle;
            arready    <= 1'b0;
            awready    <= 1'b0;
            wready     <= 1'b0;
            rvalid     <= 1'b0;
            rlast      <= 1'b0;
            bvalid     <= 1'b0;
            rd_addr    <= 32'd0;
            rd_len     <= 8'd0;
            rd_cnt     <= 8'd0;
            rd_size_ok <= 1'b0;
        end else begin
            case (state)
                ms_idle: begin
                    if (arvalid) begin
                        arready <= 1'b1;
                        state   <= ms_rd_addr;
                    end else if (awvalid && wvalid) begin
                        awready <= 1'b1;
                        wready  <= 1'b1;
                        state   <= ms_wr;
                    end
                end
                ms_rd_addr: begin
                    arready <= 1'b0;
                    if (ar_fire) begin
                        rd_addr    <= fetch_addr;
                        rd_len     <= arlen;
                        rd_cnt     <= 8'd0;
                        rd_size_ok <= (arsize == 3'd2);
                        rvalid     <= 1'b1;
                        rlast      <= (arlen == 8'd0);
                        state      <= ms_rd_data;
                    end else begin
                        // request withdrawn
                        state <= ms_idle;
                    end
                end
                ms_rd_data: begin
                    if (r_fire) begin
                        rd_cnt <= rd_cnt + 8'd1;
                        if (rd_cnt == rd_len) begin
                            rvalid <= 1'b0;
                            rlast  <= 1'b0;
                            state  <= ms_idle;
                        end else begin
                            rd_addr <= fetch_addr;
                            rlast   <= (rd_cnt + 8'd1 == rd_len);
                        end
                    end
                end
                ms_wr: begin
                    awready <= 1'b0;
                    wready  <= 1'b0;
                    if (w_fire) begin
                        bvalid <= 1'b1;
                        state  <= ms_wr_resp;
                    end else begin
                        state <= ms_idle;
                    end
                end
                ms_wr_resp: begin
                    if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        state  <= ms_idle;
                    end
                end
                default: state <= ms_idle;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // read data, responses and storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ar_fire || rd_more) begin
            rdata <= fetch_hit ? mem[word_idx(fetch_addr)] : 32'd0;
            rresp <= fetch_hit ? resp_okay : resp_decerr;
        end
        if (w_fire) begin
            bresp <= wr_hit ? resp_okay : resp_decerr;
        end
    end

    // byte lanes written under wstrb
    always_ff @(posedge clk) begin
        if (w_fire && wr_hit) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wstrb[lane]) begin
                    mem[word_idx(awaddr)][lane*8 +: 8] <= wdata[lane*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/line_fill.sv */
/*
 * Cache line fill master.
 * Aligns the request to a line boundary, issues one incrementing AXI
 * read burst of line_words beats and gathers the beats into a line,
 * word 0 in the low bits. Any non-okay beat flags an error.
 */
`timescale 1ns/1ps
`default_nettype none

module line_fill import mem_pkg::*; (
    input  wire                  clk,
    input  wire                  reset,

    // request side
    input  wire                  fill_req,
    input  wire  [31:0]          fill_addr,
    output logic                 fill_busy,
    output logic                 fill_done,
    output logic [line_bits-1:0] fill_line,
    output logic                 fill_err,

    // AXI read
    output logic [31:0]          araddr,
    output logic [7:0]           arlen,
    output logic [2:0]           arsize,
    output logic                 arvalid,
    input  wire                  arready,
    input  wire  [31:0]          rdata,
    input  wire  [1:0]           rresp,
    input  wire                  rvalid,
    input  wire                  rlast,
    output logic                 rready
);

    logic start;
    logic r_fire;

    assign start  = fill_req && !fill_busy;
    assign r_fire = rvalid && rready;

    // one burst of word beats per line
    assign arlen  = 8'(line_words - 1);
    assign arsize = 3'd2;
    assign rready = fill_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            fill_busy <= 1'b0;
            fill_done <= 1'b0;
            arvalid   <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            if (start) begin
                fill_busy <= 1'b1;
                arvalid   <= 1'b1;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
            end
            if (r_fire && rlast) begin
                fill_busy <= 1'b0;
                fill_done <= 1'b1;
            end
        end
    end

    // beats enter at the top and shift down
    always_ff @(posedge clk) begin
        if (start) begin
            araddr   <= fill_addr & ~32'(line_words * 4 - 1);
            fill_err <= 1'b0;
        end
        if (r_fire) begin
            fill_line <= {rdata, fill_line[line_bits-1:32]};
            if (rresp != resp_okay) begin
                fill_err <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mem_pkg.sv */
/*
 * Memory subsystem package.
 * Address window, line geometry, AXI response codes, store size
 * codes and the state encoding of the memory slave.
 */
`default_nettype none

package mem_pkg;

    // address window, 4 KiB of word storage
    localparam logic [31:0] base_addr    = 32'h8000_0000;
    localparam int          mem_words    = 1024;
    localparam int          mem_idx_bits = $clog2(mem_words);

    // cache line geometry
    localparam int line_words = 4;
    localparam int line_bits  = line_words * 32;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_decerr = 2'd3;

    // store size codes
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    // memory slave states
    localparam logic [2:0] ms_idle    = 3'd0;
    localparam logic [2:0] ms_rd_addr = 3'd1;
    localparam logic [2:0] ms_rd_data = 3'd2;
    localparam logic [2:0] ms_wr      = 3'd3;
    localparam logic [2:0] ms_wr_resp = 3'd4;

endpackage

`default_nettype wire

/* hw/mem_subsys.sv */
/*
 * Memory subsystem top level.
 * The line fill master uses the AXI read channels and the store port
 * uses the write channels of one memory slave.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys import mem_pkg::*; (
    input  wire                  clk,
    input  wire                  reset,

    input  wire                  fill_req,
    input  wire  [31:0]          fill_addr,
    output logic                 fill_busy,
    output logic                 fill_done,
    output logic [line_bits-1:0] fill_line,
    output logic                 fill_err,

    input  wire                  st_req,
    input  wire  [31:0]          st_addr,
    input  wire  [31:0]          st_data,
    input  wire  [1:0]           st_size,
    output logic                 st_busy,
    output logic                 st_done,
    output logic                 st_err
);

    // read channels
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rlast;
    logic        rready;

    // write channels
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wlast;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        bready;

    line_fill u_line_fill (
        .clk       (clk),
        .reset     (reset),
        .fill_req  (fill_req),
        .fill_addr (fill_addr),
        .fill_busy (fill_busy),
        .fill_done (fill_done),
        .fill_line (fill_line),
        .fill_err  (fill_err),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rlast     (rlast),
        .rready    (rready)
    );

    store_port u_store_port (
        .clk     (clk),
        .reset   (reset),
        .st_req  (st_req),
        .st_addr (st_addr),
        .st_data (st_data),
        .st_size (st_size),
        .st_busy (st_busy),
        .st_done (st_done),
        .st_err  (st_err),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wlast   (wlast),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready)
    );

    axi_mem u_axi_mem (
        .clk     (clk),
        .reset   (reset),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rlast   (rlast),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wlast   (wlast),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready)
    );

endmodule

`default_nettype wire

/* hw/store_port.sv */
/*
 * Store write master.
 * Turns a byte, half-word or word store into one AXI write beat,
 * replicating the data into every lane and enabling only the lanes
 * selected by size and address offset.
 */
`timescale 1ns/1ps
`default_nettype none

module store_port import mem_pkg::*; (
    input  wire         clk,
    input  wire         reset,

    // request side
    input  wire         st_req,
    input  wire  [31:0] st_addr,
    input  wire  [31:0] st_data,
    input  wire  [1:0]  st_size,
    output logic        st_busy,
    output logic        st_done,
    output logic        st_err,

    // AXI write
    output logic [31:0] awaddr,
    output logic        awvalid,
    input  wire         awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wvalid,
    output logic        wlast,
    input  wire         wready,
    input  wire         bvalid,
    input  wire  [1:0]  bresp,
    output logic        bready
);

    logic        start;
    logic        b_fire;
    logic [3:0]  lane_strb;
    logic [31:0] lane_data;

    assign start  = st_req && !st_busy;
    assign b_fire = bvalid && bready;
    assign bready = st_busy;
    // every write is a single beat
    assign wlast  = wvalid;

    always_comb begin
        case (st_size)
            size_byte: begin
                lane_strb = 4'b0001 << st_addr[1:0];
                lane_data = {4{st_data[7:0]}};
            end
            size_half: begin
                // halves sit at even offsets
                lane_strb = st_addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{st_data[15:0]}};
            end
            size_word: begin
                lane_strb = 4'b1111;
                lane_data = st_data;
            end
            default: begin
                // reserved size writes no lane
                lane_strb = 4'b0000;
                lane_data = st_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st_busy <= 1'b0;
            st_done <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            st_done <= 1'b0;
            if (start) begin
                st_busy <= 1'b1;
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
            end else begin
                if (awvalid && awready) begin
                    awvalid <= 1'b0;
                end
                if (wvalid && wready) begin
                    wvalid <= 1'b0;
                end
            end
            if (b_fire) begin
                st_busy <= 1'b0;
                st_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            awaddr <= st_addr;
            wdata  <= lane_data;
            wstrb  <= lane_strb;
        end
        if (b_fire) begin
            st_err <= (bresp != resp_okay);
        end
    end

endmodule

`default_nettype wire

/* verif/mem_subsys_assert.sv */
/*
 * Bound checker for the memory subsystem.
 * Keeps a shadow byte image of the memory window, updated as stores
 * complete, and checks fill data, error responses, done strobes and
 * the AXI handshake rules on the internal channels.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_assert import mem_pkg::*; (
    input wire                 clk,
    input wire                 reset,
    input wire                 fill_req,
    input wire [31:0]          fill_addr,
    input wire                 fill_busy,
    input wire                 fill_done,
    input wire [line_bits-1:0] fill_line,
    input wire                 fill_err,
    input wire                 st_req,
    input wire [31:0]          st_addr,
    input wire [31:0]          st_data,
    input wire [1:0]           st_size,
    input wire                 st_busy,
    input wire                 st_done,
    input wire                 st_err,
    input wire [31:0]          araddr,
    input wire                 arvalid,
    input wire                 arready,
    input wire                 rvalid,
    input wire                 rready,
    input wire                 rlast,
    input wire [31:0]          awaddr,
    input wire                 awvalid,
    input wire                 awready
);

    logic                 failed;
    logic [7:0]           shadow [mem_words * 4];
    logic [31:0]          st_q_addr;
    logic [31:0]          st_q_data;
    logic [1:0]           st_q_size;
    logic                 st_q_win;
    logic [31:0]          fill_q_addr;
    logic                 fill_q_win;
    logic                 fill_pend;
    logic                 st_pend;
    logic                 req_seen;
    logic [1:0]           beat_cnt;
    logic [11:0]          st_idx;
    logic [11:0]          fill_idx;
    logic [line_bits-1:0] exp_line;

    initial failed = 1'b0;

    function automatic logic window_hit(input logic [31:0] addr);
        return (addr >= base_addr) && (addr < base_addr + 32'(mem_words * 4));
    endfunction

    task automatic report_failure(input string msg);
        $error("[FAIL] %0t ns: %s", $time, msg);
        failed = 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // request tracking
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_pend <= 1'b0;
            st_pend   <= 1'b0;
            req_seen  <= 1'b0;
            beat_cnt  <= 2'd0;
        end else begin
            if (fill_req || st_req) begin
                req_seen <= 1'b1;
            end
            if (fill_req && !fill_busy) begin
                fill_pend <= 1'b1;
            end else if (fill_done) begin
                fill_pend <= 1'b0;
            end
            if (st_req && !st_busy) begin
                st_pend <= 1'b1;
            end else if (st_done) begin
                st_pend <= 1'b0;
            end
            // four beats per burst, counter wraps
            if (rvalid && rready) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st_req && !st_busy) begin
            st_q_addr <= st_addr;
            st_q_data <= st_data;
            st_q_size <= st_size;
            st_q_win  <= window_hit(st_addr);
        end
        if (fill_req && !fill_busy) begin
            fill_q_addr <= {fill_addr[31:4], 4'h0};
            fill_q_win  <= window_hit({fill_addr[31:4], 4'h0});
        end
    end

    // ------------------------------------------------------------------------
    // shadow memory, updated when a store completes
    // ------------------------------------------------------------------------
    assign st_idx   = 12'(st_q_addr - base_addr);
    assign fill_idx = 12'(fill_q_addr - base_addr);

    always_ff @(posedge clk) begin
        if (st_done && st_q_win) begin
            case (st_q_size)
                size_byte: shadow[st_idx] <= st_q_data[7:0];
                size_half: begin
                    // half lands on the even byte pair
                    shadow[{st_idx[11:1], 1'b0}] <= st_q_data[7:0];
                    shadow[{st_idx[11:1], 1'b1}] <= st_q_data[15:8];
                end
                size_word: begin
                    for (int b = 0; b < 4; b++) begin
                        shadow[{st_idx[11:2], 2'(b)}] <= st_q_data[b*8 +: 8];
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        for (int b = 0; b < line_words * 4; b++) begin
            exp_line[b*8 +: 8] = shadow[fill_idx + 12'(b)];
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    fill_data_ok: assert property (@(posedge clk) disable iff (reset)
        fill_done && fill_q_win |-> fill_line == exp_line && !fill_err)
        else report_failure("fill line differs from shadow memory");

    fill_oob_err: assert property (@(posedge clk) disable iff (reset)
        fill_done && !fill_q_win |-> fill_err)
        else report_failure("fill outside the window without error");

    st_resp_ok: assert property (@(posedge clk) disable iff (reset)
        st_done |-> st_err == !st_q_win)
        else report_failure("store error flag does not match the address window");

    idle_after_reset: assert property (@(posedge clk) disable iff (reset)
        !req_seen |-> !fill_busy && !st_busy && !fill_done && !st_done)
        else report_failure("busy or done active before any request");

    fill_done_once: assert property (@(posedge clk) disable iff (reset)
        fill_done |-> fill_pend)
        else report_failure("fill done without an accepted request");

    st_done_once: assert property (@(posedge clk) disable iff (reset)
        st_done |-> st_pend)
        else report_failure("store done without an accepted request");

    ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else report_failure("arvalid dropped or araddr changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else report_failure("awvalid dropped or awaddr changed before awready");

    rlast_fourth: assert property (@(posedge clk) disable iff (reset)
        rvalid && rready |-> rlast == (beat_cnt == 2'd3))
        else report_failure("rlast not on the fourth beat");

endmodule

bind mem_subsys mem_subsys_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .fill_req  (fill_req),
    .fill_addr (fill_addr),
    .fill_busy (fill_busy),
    .fill_done (fill_done),
    .fill_line (fill_line),
    .fill_err  (fill_err),
    .st_req    (st_req),
    .st_addr   (st_addr),
    .st_data   (st_data),
    .st_size   (st_size),
    .st_busy   (st_busy),
    .st_done   (st_done),
    .st_err    (st_err),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rvalid    (rvalid),
    .rready    (rready),
    .rlast     (rlast),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready)
);

`default_nettype wire

/* verif/tb_clock.sv */
/*
 * Testbench clock generator.
 * Free-running clock with a 4 ns period.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    // half period
    always #2 clk = ~clk;

endmodule

`default_nettype wire

/* verif/tb_mem_subsys.sv */
/*
 * Memory subsystem testbench.
 * Preloads four cache lines, then runs random stores and line fills,
 * some in the same cycle and some outside the window. The bound
 * checker does the comparisons; this module drives and reports.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 8;
    localparam int num_seqs     = 2;
    localparam int num_ops      = 200;
    // up to two requests per operation, plus the preload
    localparam int max_reqs     = num_seqs * (4 * line_words + 2 * num_ops);
    localparam int limit_cycles = max_reqs * 40 + 200;

    logic                 clk;
    logic                 reset;
    logic                 fill_req;
    logic [31:0]          fill_addr;
    logic                 fill_busy;
    logic                 fill_done;
    logic [line_bits-1:0] fill_line;
    logic                 fill_err;
    logic                 st_req;
    logic [31:0]          st_addr;
    logic [31:0]          st_data;
    logic [1:0]           st_size;
    logic                 st_busy;
    logic                 st_done;
    logic                 st_err;
    logic [31:0]          line_base [4];

    tb_clock u_clock (
        .clk (clk)
    );

    mem_subsys DUT (
        .clk       (clk),
        .reset     (reset),
        .fill_req  (fill_req),
        .fill_addr (fill_addr),
        .fill_busy (fill_busy),
        .fill_done (fill_done),
        .fill_line (fill_line),
        .fill_err  (fill_err),
        .st_req    (st_req),
        .st_addr   (st_addr),
        .st_data   (st_data),
        .st_size   (st_size),
        .st_busy   (st_busy),
        .st_done   (st_done),
        .st_err    (st_err)
    );

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // mostly one of the four lines, now and then just outside the window
    function automatic logic [31:0] pick_addr();
        logic [1:0]  k;
        logic [31:0] offs;
        k    = 2'($urandom % 4);
        offs = $urandom % 16;
        if ($urandom % 16 == 0) begin
            if ($urandom % 2 == 0) begin
                return base_addr + 32'(mem_words * 4) + offs;
            end
            return base_addr - 32'd16 + offs;
        end
        return line_base[k] + offs;
    endfunction

    task automatic issue(
        input logic        fill_on,
        input logic [31:0] f_addr,
        input logic        st_on,
        input logic [31:0] s_addr,
        input logic [31:0] s_data,
        input logic [1:0]  s_size,
        input logic        extra
    );
        logic got_fill;
        logic got_st;
        fill_req  = fill_on;
        fill_addr = f_addr;
        st_req    = st_on;
        st_addr   = s_addr;
        st_data   = s_data;
        st_size   = s_size;
        next_cycle();
        // repeat request lands while busy and is dropped
        fill_req  = fill_on && extra;
        st_req    = st_on && extra;
        fill_addr = ~f_addr;
        st_addr   = ~s_addr;
        got_fill  = !fill_on;
        got_st    = !st_on;
        while (!(got_fill && got_st)) begin
            next_cycle();
            fill_req = 1'b0;
            st_req   = 1'b0;
            if (fill_done) begin
                got_fill = 1'b1;
            end
            if (st_done) begin
                got_st = 1'b1;
            end
        end
    endtask

    task automatic preload_lines();
        for (int i = 0; i < 4 * line_words; i++) begin
            issue(1'b0, 32'd0, 1'b1,
                  line_base[2'(i / line_words)] + 32'(4 * (i % line_words)),
                  $urandom, size_word, 1'b0);
        end
    endtask

    // watchdog
    initial begin
        #(limit_cycles * clk_period);
        $display("timeout: no completion seen");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        @(posedge DUT.u_assert.failed);
        $display("Simulation failed");
        $fatal(1, "checker flagged an error");
    end

    initial begin
        int   sel;
        logic fill_on;
        logic st_on;
        void'($urandom(99592));
        line_base[0] = base_addr;
        line_base[1] = base_addr + 32'h10;
        line_base[2] = base_addr + 32'h7f0;
        line_base[3] = base_addr + 32'(mem_words * 4 - 16);
        reset     = 1'b1;
        fill_req  = 1'b0;
        fill_addr = 32'd0;
        st_req    = 1'b0;
        st_addr   = 32'd0;
        st_data   = 32'd0;
        st_size   = size_byte;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        // a few quiet cycles after reset
        repeat (4) next_cycle();

        for (int s = 0; s < num_seqs; s++) begin
            preload_lines();
            for (int op = 0; op < num_ops; op++) begin
                sel     = int'($urandom % 8);
                fill_on = (sel >= 4);
                st_on   = (sel < 4) || (sel == 7);
                issue(fill_on, pick_addr(), st_on, pick_addr(), $urandom,
                      2'($urandom % 3), ($urandom % 4) == 0);
            end
        end

        repeat (4) next_cycle();
        if (DUT.u_assert.failed) begin
            $display("Simulation failed");
            $fatal(1, "checker flagged an error");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
